// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // data and address width
  localparam int XLEN = 32;

  // register index width
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // major opcodes the core executes
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_REG_IMM = 7'b0010011;
  localparam opcode_t OP_REG_REG = 7'b0110011;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_SYSTEM  = 7'b1110011;

  // funct7 that turns ADD into SUB and SRL into SRA
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

endpackage

`default_nettype wire

// ==== source/insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  rv_pkg::word_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output logic             use_imm,
  output rv_pkg::alu_op_t  alu_op,
  output logic             reg_write,
  output logic             is_lui,
  output logic             is_branch,
  output logic [2:0]       branch_funct,
  output logic             is_ecall
);

  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_reg_imm;
  logic       is_reg_reg;
  logic       f7_zero;
  logic       f7_alt;
  logic       funct7_ok;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;

  // fixed field positions shared by all formats
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{(XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  // B immediate is scrambled in the encoding, bit 0 is always zero
  assign imm_b = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  assign is_lui     = opcode == OP_LUI;
  assign is_reg_imm = opcode == OP_REG_IMM;
  assign is_reg_reg = opcode == OP_REG_REG;
  assign is_branch  = opcode == OP_BRANCH;
  assign is_ecall   = (opcode == OP_SYSTEM) && (insn[31:7] == '0);

  assign branch_funct = funct3;
  assign use_imm      = is_reg_imm;

  assign f7_zero = funct7 == 7'b0;
  assign f7_alt  = funct7 == FUNCT7_ALT;

  always_comb
  begin
    case (opcode)
      OP_REG_IMM: imm = imm_i;
      OP_LUI:     imm = imm_u;
      OP_BRANCH:  imm = imm_b;
      default:    imm = '0;
    endcase
  end

  // funct3 picks the operation, the alt bit selects SUB or SRA
  always_comb
  begin
    case (funct3)
      3'b000:  alu_op = (is_reg_reg && f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  // immediate forms carry funct7 only for the shifts
  always_comb
  begin
    if (is_reg_imm)
    begin
      case (funct3)
        3'b001:  funct7_ok = f7_zero;
        3'b101:  funct7_ok = f7_zero || f7_alt;
        default: funct7_ok = 1'b1;
      endcase
    end
    else
    begin
      case (funct3)
        3'b000,
        3'b101:  funct7_ok = f7_zero || f7_alt;
        default: funct7_ok = f7_zero;
      endcase
    end
  end

  // anything not recognised just falls through to pc + 4
  assign reg_write = is_lui || ((is_reg_imm || is_reg_reg) && funct7_ok);

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::word_t    wr_data,
  input  rv_pkg::reg_idx_t rd_idx_a,
  output rv_pkg::word_t    rd_data_a,
  input  rv_pkg::reg_idx_t rd_idx_b,
  output rv_pkg::word_t    rd_data_b
);

  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we && (wr_idx != '0))
    begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts only look at the low five bits of b
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb
  begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      // fills from the sign bit
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          halt,
  input  logic          is_branch,
  input  logic [2:0]    branch_funct,
  input  rv_pkg::word_t a,
  input  rv_pkg::word_t b,
  input  rv_pkg::word_t imm,
  output rv_pkg::word_t pc
);

  import rv_pkg::*;

  logic  cond;
  logic  taken;
  word_t pc_next;

  // branch condition by funct3
  always_comb
  begin
    case (branch_funct)
      3'b000:  cond = a == b;
      3'b001:  cond = a != b;
      3'b100:  cond = $signed(a) < $signed(b);
      3'b101:  cond = $signed(a) >= $signed(b);
      3'b110:  cond = a < b;
      3'b111:  cond = a >= b;
      // 010 and 011 are not branches
      default: cond = 1'b0;
    endcase
  end

  assign taken = is_branch && cond;

  always_comb
  begin
    if (halt)
      pc_next = pc;
    else if (taken)
      pc_next = pc + imm;
    else
      pc_next = pc + word_t'(4);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      pc <= RESET_PC;
    else
      pc <= pc_next;
  end

endmodule

`default_nettype wire

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::word_t    pc,
  input  rv_pkg::word_t    insn,
  output logic             wb_we,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data,
  output logic             halt
);

  import rv_pkg::*;

  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      imm;
  logic       use_imm;
  alu_op_t    alu_op;
  logic       reg_write;
  logic       is_lui;
  logic       is_branch;
  logic [2:0] branch_funct;
  logic       is_ecall;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_b;
  word_t      alu_result;

  insn_decoder dec_i (
    .insn         (insn),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .imm          (imm),
    .use_imm      (use_imm),
    .alu_op       (alu_op),
    .reg_write    (reg_write),
    .is_lui       (is_lui),
    .is_branch    (is_branch),
    .branch_funct (branch_funct),
    .is_ecall     (is_ecall)
  );

  reg_file rf_i (
    .clk       (clk),
    .rst       (rst),
    .we        (wb_we),
    .wr_idx    (wb_rd),
    .wr_data   (wb_data),
    .rd_idx_a  (rs1),
    .rd_data_a (rs1_data),
    .rd_idx_b  (rs2),
    .rd_data_b (rs2_data)
  );

  // second operand is the immediate for the reg-imm group
  assign alu_b = use_imm ? imm : rs2_data;

  alu alu_i (
    .op     (alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) pc_i (
    .clk          (clk),
    .rst          (rst),
    .halt         (halt),
    .is_branch    (is_branch),
    .branch_funct (branch_funct),
    .a            (rs1_data),
    .b            (rs2_data),
    .imm          (imm),
    .pc           (pc)
  );

  // retire port doubles as the register file write port
  assign wb_we   = reg_write && !rst;
  assign wb_rd   = rd;
  assign wb_data = is_lui ? imm : alu_result;
  assign halt    = is_ecall && !rst;

endmodule

`default_nettype wire

// ==== verification/rv_core_tb_enc.svh ====
`ifndef RV_CORE_TB_ENC_SVH
`define RV_CORE_TB_ENC_SVH

// funct3 codes of the ALU groups
localparam int F3_ADD  = 0;
localparam int F3_SLL  = 1;
localparam int F3_SLT  = 2;
localparam int F3_SLTU = 3;
localparam int F3_XOR  = 4;
localparam int F3_SR   = 5;
localparam int F3_OR   = 6;
localparam int F3_AND  = 7;

// funct3 codes of the branches
localparam int F3_BEQ  = 0;
localparam int F3_BNE  = 1;
localparam int F3_BLT  = 4;
localparam int F3_BGE  = 5;
localparam int F3_BLTU = 6;
localparam int F3_BGEU = 7;

localparam int          F7_ALT     = 'h20;
localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

function automatic logic [31:0] enc_r(int f7, int f3, int rd, int rs1, int rs2);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG_REG};
endfunction

function automatic logic [31:0] enc_i(int f3, int rd, int rs1, int imm);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG_IMM};
endfunction

// immediate shifts keep funct7 in the top of the immediate
function automatic logic [31:0] enc_sh(int f7, int f3, int rd, int rs1, int shamt);
  return {f7[6:0], shamt[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG_IMM};
endfunction

function automatic logic [31:0] enc_lui(int rd, int imm20);
  return {imm20[19:0], rd[4:0], OP_LUI};
endfunction

function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] lfsr_next(logic [31:0] state);
  return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
endfunction

`endif

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  import rv_pkg::*;

  `include "rv_core_tb_enc.svh"

  localparam logic [31:0] RESET_ADDR = 32'h0;
  localparam int          IMEM_WORDS = 256;
  localparam int          HALT_LIMIT = 400;
  localparam logic [31:0] LFSR_SEED  = 32'h8cb0;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  // ecall on the bus before the first edge, so reset has to mask halt
  logic [31:0] insn = ECALL_WORD;
  logic [31:0] pc;
  logic        wb_we;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        halt;

  logic [31:0] imem [0:IMEM_WORDS-1];
  int          prog_len;
  logic [31:0] lfsr;

  // reference model state and its view of the instruction at exp_pc
  logic [31:0] model_regs [0:31];
  logic [31:0] exp_pc;
  logic [31:0] exp_next;
  logic [31:0] exp_data;
  logic [4:0]  exp_rd;
  logic        exp_we;
  logic        exp_halt;
  logic [6:0]  m_op;
  logic [2:0]  m_f3;
  logic        m_alt;
  logic [31:0] m_a;
  logic [31:0] m_b;
  logic [31:0] m_rs2v;
  logic [31:0] m_immb;
  logic [4:0]  m_sh;
  logic        m_taken;

  rv_core_top #(
    .RESET_PC (RESET_ADDR)
  ) dut_i (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .insn    (insn),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .halt    (halt)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_mismatch(input string what);
    $display("[ERROR] %0d ns: %s", $time, what);
    stop_with_failure();
  endtask

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  // one LFSR step per bit, first bit lands in the msb
  task automatic draw(input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // taken branch jumps over a write to x7, the not-taken one falls into x6 += 1
  task automatic branch_pair(input int f3, input int ta, input int tb, input int na, input int nb);
    emit(enc_b(f3, ta, tb, 8));
    emit(enc_i(F3_ADD, 7, 0, 99));
    emit(enc_b(f3, na, nb, 8));
    emit(enc_i(F3_ADD, 6, 6, 1));
  endtask

  always_comb
  begin
    m_op     = insn[6:0];
    m_f3     = insn[14:12];
    m_alt    = insn[31:25] == 7'b0100000;
    m_a      = model_regs[insn[19:15]];
    m_rs2v   = model_regs[insn[24:20]];
    m_b      = (m_op == OP_REG_IMM) ? {{20{insn[31]}}, insn[31:20]} : m_rs2v;
    m_sh     = m_b[4:0];
    m_immb   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    exp_rd   = insn[11:7];
    exp_we   = (m_op == OP_LUI) || (m_op == OP_REG_IMM) || (m_op == OP_REG_REG);
    exp_halt = insn == ECALL_WORD;
    case (m_f3)
      3'd0:    exp_data = (m_op == OP_REG_REG && m_alt) ? m_a - m_b : m_a + m_b;
      3'd1:    exp_data = m_a << m_sh;
      3'd2:    exp_data = {31'b0, $signed(m_a) < $signed(m_b)};
      3'd3:    exp_data = {31'b0, m_a < m_b};
      3'd4:    exp_data = m_a ^ m_b;
      // arithmetic shift as a logical shift with the vacated bits filled by the sign
      3'd5:    exp_data = m_alt ? ((m_a >> m_sh) | ({32{m_a[31]}} & ~(32'hffff_ffff >> m_sh)))
                                : (m_a >> m_sh);
      3'd6:    exp_data = m_a | m_b;
      default: exp_data = m_a & m_b;
    endcase
    if (m_op == OP_LUI)
      exp_data = {insn[31:12], 12'h000};
    case (m_f3)
      3'd0:    m_taken = m_a == m_rs2v;
      3'd1:    m_taken = m_a != m_rs2v;
      3'd4:    m_taken = $signed(m_a) < $signed(m_rs2v);
      3'd5:    m_taken = $signed(m_a) >= $signed(m_rs2v);
      3'd6:    m_taken = m_a < m_rs2v;
      3'd7:    m_taken = m_a >= m_rs2v;
      default: m_taken = 1'b0;
    endcase
    if (m_op != OP_BRANCH)
      m_taken = 1'b0;
    if (exp_halt)
      exp_next = exp_pc;
    else if (m_taken)
      exp_next = exp_pc + m_immb;
    else
      exp_next = exp_pc + 32'd4;
  end

  // next fetch follows the predicted pc, pc_tracks flags any drift of the core
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
        model_regs[i] <= '0;
      exp_pc <= RESET_ADDR;
      insn   <= imem[RESET_ADDR[9:2]];
    end
    else
    begin
      if (exp_we && exp_rd != 5'd0)
        model_regs[exp_rd] <= exp_data;
      exp_pc <= exp_next;
      insn   <= imem[exp_next[9:2]];
    end
  end

  reset_quiet: assert property (@(posedge clk) rst |-> (!wb_we && !halt))
    else report_mismatch("retire or halt active during reset");
  pc_tracks: assert property (@(posedge clk) disable iff (rst) pc == exp_pc)
    else report_mismatch($sformatf("pc %h, expected %h", $sampled(pc), $sampled(exp_pc)));
  we_tracks: assert property (@(posedge clk) disable iff (rst) wb_we == exp_we)
    else report_mismatch($sformatf("wb_we %b at pc %h", $sampled(wb_we), $sampled(pc)));
  rd_tracks: assert property (@(posedge clk) disable iff (rst) exp_we |-> wb_rd == exp_rd)
    else report_mismatch($sformatf("wb_rd %0d, expected %0d",
                                   $sampled(wb_rd), $sampled(exp_rd)));
  data_tracks: assert property (@(posedge clk) disable iff (rst) exp_we |-> wb_data == exp_data)
    else report_mismatch($sformatf("wb_data %h, expected %h",
                                   $sampled(wb_data), $sampled(exp_data)));
  halt_tracks: assert property (@(posedge clk) disable iff (rst) halt == exp_halt)
    else report_mismatch($sformatf("halt %b at pc %h", $sampled(halt), $sampled(pc)));
  halt_no_write: assert property (@(posedge clk) halt |-> !wb_we)
    else report_mismatch("register write while halted");

  initial
  begin
    int kind, f3, rd, rs1, rs2, alt, imm, f7;
    int cycles;
    logic [31:0] halt_pc;
    // unused words hold addi x0, x0, index
    for (int i = 0; i < IMEM_WORDS; i++)
      imem[i] = enc_i(F3_ADD, 0, 0, i);
    prog_len = 0;
    lfsr = LFSR_SEED;
    emit(enc_lui(1, 'h12345));
    emit(enc_i(F3_ADD, 1, 1, 'h678));
    emit(enc_lui(2, 'hf0000));
    emit(enc_i(F3_ADD, 2, 2, -1365));
    emit(enc_i(F3_SLT, 3, 2, -7));
    emit(enc_i(F3_SLTU, 4, 1, -7));
    emit(enc_i(F3_XOR, 5, 1, 'h5a5));
    emit(enc_i(F3_OR, 6, 2, 'h0f0));
    emit(enc_i(F3_AND, 7, 1, -256));
    emit(enc_sh(0, F3_SLL, 8, 1, 7));
    emit(enc_sh(0, F3_SR, 9, 2, 9));
    emit(enc_sh(F7_ALT, F3_SR, 10, 2, 9));
    emit(enc_r(0, F3_ADD, 11, 1, 2));
    emit(enc_r(F7_ALT, F3_ADD, 12, 1, 2));
    emit(enc_r(0, F3_SLL, 13, 1, 9));
    emit(enc_r(0, F3_SLT, 14, 2, 1));
    emit(enc_r(0, F3_SLTU, 15, 2, 1));
    emit(enc_r(0, F3_XOR, 16, 1, 2));
    emit(enc_r(0, F3_SR, 17, 2, 9));
    emit(enc_r(F7_ALT, F3_SR, 18, 2, 9));
    emit(enc_r(0, F3_OR, 19, 1, 2));
    emit(enc_r(0, F3_AND, 20, 1, 2));
    // x0 write retires but must not stick
    emit(enc_i(F3_ADD, 0, 0, 55));
    emit(enc_r(0, F3_ADD, 21, 0, 0));
    emit(enc_i(F3_ADD, 1, 0, 5));
    emit(enc_i(F3_ADD, 2, 0, -3));
    emit(enc_i(F3_ADD, 3, 0, 5));
    branch_pair(F3_BEQ, 1, 3, 1, 2);
    branch_pair(F3_BNE, 1, 2, 1, 3);
    branch_pair(F3_BLT, 2, 1, 1, 2);
    branch_pair(F3_BGE, 1, 2, 2, 1);
    branch_pair(F3_BLTU, 1, 2, 2, 1);
    branch_pair(F3_BGEU, 2, 1, 1, 2);
    for (int n = 0; n < 40; n++)
    begin
      draw(1, kind);
      draw(3, f3);
      draw(3, rd);
      draw(3, rs1);
      draw(3, rs2);
      draw(1, alt);
      draw(12, imm);
      // only SUB and SRA/SRAI carry the alt funct7
      f7 = (alt == 1 && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : 0;
      if (kind == 1)
        emit(enc_r(f7, f3, rd, rs1, rs2));
      else if (f3 == F3_SLL || f3 == F3_SR)
        emit(enc_sh(f7, f3, rd, rs1, imm % 32));
      else
        emit(enc_i(f3, rd, rs1, imm));
    end
    emit(ECALL_WORD);

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!halt && cycles < HALT_LIMIT);

    if (!halt)
    begin
      $display("ECALL was not reached within %0d cycles", HALT_LIMIT);
      stop_with_failure();
    end
    else
    begin
      halt_pc = pc;
      for (cycles = 0; cycles < 5; cycles++)
        @(negedge clk);
      hold_check: assert (halt && !wb_we && pc == halt_pc)
        else report_mismatch($sformatf("pc %h left halt pc %h", pc, halt_pc));
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
source/rv_pkg.sv
source/insn_decoder.sv
source/reg_file.sv
source/alu.sv
source/pc_unit.sv
source/rv_core_top.sv
verification/rv_core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
TOP        ?= rv_core_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
